/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

  localparam int mem_tag_bits = 4;  // tag 0 means no tag
  localparam int bus_addr_bits = 32;
  localparam int bus_data_bits = 64;

  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_command_e;

  typedef struct packed {
    bus_command_e             command;
    logic [bus_addr_bits-1:0] addr;
    logic [bus_data_bits-1:0] data;
  } mem_request_t;

endpackage

/* design/dcache_types_pkg.sv */
package dcache_types_pkg;

  localparam int addr_width = 32;
  localparam int block_bytes = 8;
  localparam int block_bits = block_bytes * 8;
  localparam int offset_bits = $clog2(block_bytes);
  localparam int index_bits = 5;
  localparam int num_lines = 1 << index_bits;
  localparam int tag_bits = addr_width - index_bits - offset_bits;  // 24
  localparam int word_bytes = 4;
  localparam int word_bits = word_bytes * 8;
  localparam int queue_depth = 16;
  localparam int queue_ptr_bits = 4;

  typedef struct packed {
    logic                  start;
    logic [addr_width-1:0] addr;  // word aligned
  } load_request_t;

  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic [word_bits-1:0]  data;
    logic [word_bytes-1:0] byte_en;
  } store_request_t;

  // store placed into its half of the block
  typedef struct packed {
    logic                   valid;
    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  index;
    logic [block_bits-1:0]  data;
    logic [block_bytes-1:0] byte_en;
  } block_write_t;

  typedef struct packed {
    logic [tag_bits-1:0]   tag;
    logic [index_bits-1:0] index;
    logic                  upper;
  } block_lookup_t;

  typedef struct packed {
    logic [addr_width-1:0]                 block_addr;
    mem_bus_pkg::bus_command_e             command;
    logic [mem_bus_pkg::mem_tag_bits-1:0]  mem_tag;
    logic                                  issued;
    logic                                  upper;
    logic                                  broadcast;
    logic [block_bits-1:0]                 data;  // pending store bytes
    logic [block_bytes-1:0]                byte_en;
    logic                                  store_merge;
  } mshr_entry_t;

  typedef struct packed {
    logic                   valid;
    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  index;
    logic [block_bits-1:0]  data;
    logic [block_bytes-1:0] merge_en;
    logic                   dirty;
  } fill_t;

  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] block_addr;
    logic [block_bits-1:0] data;
  } eviction_t;

endpackage

/* design/dcache_request_stage.sv */
module dcache_request_stage
  import dcache_types_pkg::*;
(
  input  load_request_t  load_in,
  input  store_request_t store_in,
  output block_lookup_t  lookup,
  output block_write_t   block_write
);

  logic store_upper;

  assign store_upper = store_in.addr[offset_bits-1];

  // load side only needs the address split
  always_comb begin
    lookup.tag = load_in.addr[addr_width-1 -: tag_bits];
    lookup.index = load_in.addr[offset_bits +: index_bits];
    lookup.upper = load_in.addr[offset_bits-1];
  end

  always_comb begin
    block_write.valid = store_in.valid;
    block_write.tag = store_in.addr[addr_width-1 -: tag_bits];
    block_write.index = store_in.addr[offset_bits +: index_bits];
    if (store_upper) begin
      block_write.data = {store_in.data, {word_bits{1'b0}}};
      block_write.byte_en = {store_in.byte_en, {word_bytes{1'b0}}};
    end else begin
      block_write.data = {{word_bits{1'b0}}, store_in.data};
      block_write.byte_en = {{word_bytes{1'b0}}, store_in.byte_en};
    end
  end

endmodule

/* design/dcache_array.sv */
module dcache_array
  import dcache_types_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  block_lookup_t        lookup,
  input  block_write_t         block_write,
  input  logic                 store_taken,
  input  fill_t                fill,
  output logic                 load_hit,
  output logic [word_bits-1:0] load_data,
  output logic                 store_hit,
  output eviction_t            eviction
);

  logic [num_lines-1:0]  line_valid;
  logic [num_lines-1:0]  line_dirty;
  logic [tag_bits-1:0]   line_tag [num_lines];
  logic [block_bits-1:0] line_data [num_lines];

  logic [block_bits-1:0] read_block;
  logic [block_bits-1:0] store_mask;
  logic [block_bits-1:0] store_block;
  logic [block_bits-1:0] fill_mask;
  logic [block_bits-1:0] fill_block;
  logic                  fill_same_block;
  logic                  store_write;

  // load port
  always_comb begin
    read_block = line_data[lookup.index];
    load_hit = line_valid[lookup.index] && (line_tag[lookup.index] == lookup.tag);
    load_data = lookup.upper ? read_block[block_bits-1 -: word_bits] : read_block[word_bits-1:0];
  end

  assign store_hit = block_write.valid && line_valid[block_write.index] &&
                     (line_tag[block_write.index] == block_write.tag);
  assign store_write = store_taken && store_hit;

  // byte enables widened to bit masks
  always_comb begin
    for (int j = 0; j < block_bytes; j++) begin
      store_mask[8*j +: 8] = {8{block_write.byte_en[j]}};
      fill_mask[8*j +: 8] = {8{fill.merge_en[j]}};
    end
  end

  assign store_block = (line_data[block_write.index] & ~store_mask) |
                       (block_write.data & store_mask);

  // block already resident, only lay the merge bytes on top
  assign fill_same_block = line_valid[fill.index] && (line_tag[fill.index] == fill.tag);

  always_comb begin
    if (fill_same_block) begin
      fill_block = (line_data[fill.index] & ~fill_mask) | (fill.data & fill_mask);
    end else begin
      fill_block = fill.data;
    end
  end

  // displaced dirty line goes back to memory
  always_comb begin
    eviction.valid = fill.valid && line_valid[fill.index] && line_dirty[fill.index] &&
                     !fill_same_block;
    eviction.block_addr = {line_tag[fill.index], fill.index, {offset_bits{1'b0}}};
    eviction.data = line_data[fill.index];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
      line_dirty <= '0;
    end else begin
      if (store_write) begin
        line_dirty[block_write.index] <= 1'b1;
      end
      if (fill.valid) begin
        line_valid[fill.index] <= 1'b1;
        line_dirty[fill.index] <= fill.dirty || (fill_same_block && line_dirty[fill.index]);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store_write) begin
      line_data[block_write.index] <= store_block;
    end
    if (fill.valid) begin
      line_data[fill.index] <= fill_block;
      line_tag[fill.index] <= fill.tag;
    end
  end

endmodule

/* design/dcache_miss_queue.sv */
module dcache_miss_queue
  import dcache_types_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  input  load_request_t            load_in,
  input  logic                     load_hit,
  input  block_write_t             block_write,
  input  logic                     store_hit,
  input  eviction_t                eviction,
  output logic                     store_taken,
  output logic                     load_stall,
  output logic                     store_stall,
  output fill_t                    fill,
  output logic                     broadcast_valid,
  output logic [word_bits-1:0]     broadcast_data,
  output mem_request_t             mem_request,
  input  logic [mem_tag_bits-1:0]  mem_response,
  input  logic [mem_tag_bits-1:0]  mem_tag,
  input  logic [bus_data_bits-1:0] mem_data
);

  mshr_entry_t entries [queue_depth];

  logic [queue_ptr_bits-1:0] head;
  logic [queue_ptr_bits-1:0] issue;
  logic [queue_ptr_bits-1:0] tail;
  logic [queue_ptr_bits-1:0] tail_store;
  logic [queue_ptr_bits-1:0] tail_evict;
  logic [queue_ptr_bits:0]   free_seats;
  logic [queue_ptr_bits:0]   free_after_load;

  logic [addr_width-1:0] load_block_addr;
  logic [addr_width-1:0] store_block_addr;
  logic                  load_miss;
  logic                  load_alloc;
  logic                  store_alloc;
  logic                  load_block_busy;
  logic                  store_block_busy;
  logic                  merge_pending;
  logic                  fill_conflict;
  logic                  issue_ready;
  logic                  issue_accept;
  logic                  head_retire;
  logic                  retire_found;
  logic [queue_ptr_bits-1:0] retire_idx;
  mshr_entry_t           retire_entry;
  mshr_entry_t           load_entry;
  mshr_entry_t           store_entry;
  mshr_entry_t           evict_entry;

  assign load_block_addr = {load_in.addr[addr_width-1:offset_bits], {offset_bits{1'b0}}};
  assign store_block_addr = {block_write.tag, block_write.index, {offset_bits{1'b0}}};

  // outstanding fills per block, at most one at a time
  always_comb begin
    merge_pending = 1'b0;
    load_block_busy = 1'b0;
    store_block_busy = 1'b0;
    for (int i = 0; i < queue_depth; i++) begin
      if (entries[i].command == bus_load) begin
        merge_pending = merge_pending || entries[i].store_merge;
        load_block_busy = load_block_busy || (entries[i].block_addr == load_block_addr);
        store_block_busy = store_block_busy || (entries[i].block_addr == store_block_addr);
      end
    end
  end

  // one seat always kept free for an eviction store
  assign free_seats = (queue_ptr_bits + 1)'(queue_depth - 1) - {1'b0, tail - head};
  assign load_miss = load_in.start && !load_hit;
  assign load_stall = (free_seats < 2) || (load_miss && load_block_busy);
  assign load_alloc = load_miss && !load_stall;
  assign free_after_load = free_seats - (queue_ptr_bits + 1)'(load_alloc);

  assign fill_conflict = fill.valid && (fill.index == block_write.index);  // line being replaced
  assign store_stall = (free_after_load < 2) || merge_pending || store_block_busy || fill_conflict;
  assign store_taken = block_write.valid && !store_stall;
  assign store_alloc = store_taken && !store_hit;

  assign tail_store = tail + queue_ptr_bits'(load_alloc);
  assign tail_evict = tail_store + queue_ptr_bits'(store_alloc);

  always_comb begin
    load_entry = '0;
    load_entry.block_addr = load_block_addr;
    load_entry.command = bus_load;
    load_entry.upper = load_in.addr[offset_bits-1];
    load_entry.broadcast = 1'b1;

    store_entry = '0;
    store_entry.block_addr = store_block_addr;
    store_entry.command = bus_load;  // write-allocate fetch
    store_entry.data = block_write.data;
    store_entry.byte_en = block_write.byte_en;
    store_entry.store_merge = 1'b1;

    evict_entry = '0;
    evict_entry.block_addr = eviction.block_addr;
    evict_entry.command = bus_store;
    evict_entry.data = eviction.data;
  end

  // bus issue
  assign issue_ready = (issue != tail) && !entries[issue].issued;
  assign issue_accept = issue_ready && (mem_response != '0);

  always_comb begin
    mem_request.command = bus_none;
    mem_request.addr = '0;
    mem_request.data = '0;
    if (issue_ready) begin
      mem_request.command = entries[issue].command;
      mem_request.addr = entries[issue].block_addr;
      mem_request.data = entries[issue].data;
    end
  end

  // loads may come back out of order, match by tag
  always_comb begin
    retire_found = 1'b0;
    retire_idx = '0;
    for (int i = 0; i < queue_depth; i++) begin
      if (entries[i].issued && (entries[i].command == bus_load) &&
          (mem_tag != '0) && (entries[i].mem_tag == mem_tag)) begin
        retire_found = 1'b1;
        retire_idx = queue_ptr_bits'(i);
      end
    end
    retire_entry = entries[retire_idx];
  end

  always_comb begin
    fill.valid = retire_found;
    fill.tag = retire_entry.block_addr[addr_width-1 -: tag_bits];
    fill.index = retire_entry.block_addr[offset_bits +: index_bits];
    fill.merge_en = retire_entry.byte_en;
    fill.dirty = retire_entry.store_merge;
    for (int j = 0; j < block_bytes; j++) begin
      fill.data[8*j +: 8] = retire_entry.byte_en[j] ? retire_entry.data[8*j +: 8]
                                                    : mem_data[8*j +: 8];
    end
  end

  assign broadcast_valid = retire_found && retire_entry.broadcast;
  assign broadcast_data = retire_entry.upper ? mem_data[bus_data_bits-1 -: word_bits]
                                             : mem_data[word_bits-1:0];

  // stores leave at head, finished loads are already bus_none
  assign head_retire = (head != issue) && entries[head].issued &&
                       ((entries[head].command == bus_store) || (entries[head].command == bus_none));

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      issue <= '0;
      tail <= '0;
      for (int i = 0; i < queue_depth; i++) begin
        entries[i] <= '0;
      end
    end else begin
      if (issue_accept) begin
        entries[issue].issued <= 1'b1;
        entries[issue].mem_tag <= mem_response;
        issue <= issue + 1'b1;
      end
      if (retire_found) begin
        entries[retire_idx].command <= bus_none;
        entries[retire_idx].store_merge <= 1'b0;
      end
      if (head_retire) begin
        entries[head] <= '0;
        head <= head + 1'b1;
      end
      if (load_alloc) begin
        entries[tail] <= load_entry;
      end
      if (store_alloc) begin
        entries[tail_store] <= store_entry;
      end
      if (eviction.valid) begin
        entries[tail_evict] <= evict_entry;
      end
      tail <= tail_evict + queue_ptr_bits'(eviction.valid);
    end
  end

endmodule

/* design/dcache.sv */
module dcache
  import dcache_types_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  // core side
  input  load_request_t            load_in,
  output logic                     load_hit,
  output logic [word_bits-1:0]     load_data,
  output logic                     load_stall,
  input  store_request_t           store_in,
  output logic                     store_stall,
  output logic                     broadcast_valid,
  output logic [word_bits-1:0]     broadcast_data,
  // memory controller side
  output mem_request_t             mem_request,
  input  logic [mem_tag_bits-1:0]  mem_response,
  input  logic [mem_tag_bits-1:0]  mem_tag,
  input  logic [bus_data_bits-1:0] mem_data
);

  block_lookup_t lookup;
  block_write_t  block_write;
  logic          store_hit;
  logic          store_taken;
  fill_t         fill;
  eviction_t     eviction;

  dcache_request_stage request_stage_i (
    .load_in     (load_in),
    .store_in    (store_in),
    .lookup      (lookup),
    .block_write (block_write)
  );

  dcache_array array_i (
    .clock       (clock),
    .reset       (reset),
    .lookup      (lookup),
    .block_write (block_write),
    .store_taken (store_taken),
    .fill        (fill),
    .load_hit    (load_hit),
    .load_data   (load_data),
    .store_hit   (store_hit),
    .eviction    (eviction)
  );

  dcache_miss_queue miss_queue_i (
    .clock           (clock),
    .reset           (reset),
    .load_in         (load_in),
    .load_hit        (load_hit),
    .block_write     (block_write),
    .store_hit       (store_hit),
    .eviction        (eviction),
    .store_taken     (store_taken),
    .load_stall      (load_stall),
    .store_stall     (store_stall),
    .fill            (fill),
    .broadcast_valid (broadcast_valid),
    .broadcast_data  (broadcast_data),
    .mem_request     (mem_request),
    .mem_response    (mem_response),
    .mem_tag         (mem_tag),
    .mem_data        (mem_data)
  );

endmodule

/* testbench/mem_controller_model.sv */
module mem_controller_model
  import mem_bus_pkg::*;
#(
  parameter logic [31:0] pattern_key = 32'h0
) (
  input  logic                     clock,
  input  logic                     reset,
  input  mem_request_t             mem_request,
  output logic [mem_tag_bits-1:0]  mem_response,
  output logic [mem_tag_bits-1:0]  mem_tag,
  output logic [bus_data_bits-1:0] mem_data
);

  logic [bus_data_bits-1:0] blocks [logic [31:0]];  // written blocks only
  logic [mem_tag_bits-1:0]  return_tags [$];
  logic [bus_data_bits-1:0] return_data [$];
  int                       return_due [$];
  logic [31:0]              rand_state = 32'h181bd096;
  logic [mem_tag_bits-1:0]  next_tag;
  int                       wait_left;
  int                       cycle;
  int                       ready_idx;

  function automatic int random_below(int limit);
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return int'(rand_state[31:16]) % limit;
  endfunction

  function automatic logic [bus_data_bits-1:0] read_block(logic [31:0] addr);
    if (blocks.exists(addr)) begin
      return blocks[addr];
    end
    return {(addr + 32'd4) ^ pattern_key, addr ^ pattern_key};
  endfunction

  task automatic accept_request();
    mem_response = next_tag;
    if (mem_request.command == bus_store) begin
      blocks[mem_request.addr] = mem_request.data;
    end else begin
      return_tags.push_back(next_tag);
      return_data.push_back(read_block(mem_request.addr));
      return_due.push_back(cycle + 2 + random_below(5));  // 2 to 6 cycles
    end
    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
  endtask

  initial begin
    mem_response = '0;
    mem_tag = '0;
    mem_data = '0;
    next_tag = 4'd1;
    wait_left = -1;
    cycle = 0;
    forever begin
      @(posedge clock);
      #10;
      cycle++;
      mem_response = '0;
      mem_tag = '0;
      mem_data = '0;
      if (!reset && mem_request.command != bus_none) begin
        if (wait_left < 0) begin
          wait_left = random_below(4);
        end
        if (wait_left == 0) begin
          accept_request();
        end
        wait_left--;
      end
      // one return per cycle, oldest first
      ready_idx = -1;
      foreach (return_due[i]) begin
        if (ready_idx < 0 && return_due[i] <= cycle) begin
          ready_idx = i;
        end
      end
      if (ready_idx >= 0) begin
        mem_tag = return_tags[ready_idx];
        mem_data = return_data[ready_idx];
        return_tags.delete(ready_idx);
        return_data.delete(ready_idx);
        return_due.delete(ready_idx);
      end
    end
  end

endmodule

/* testbench/dcache_tb.sv */
module dcache_tb
  import dcache_types_pkg::*;
  import mem_bus_pkg::*;
();

  localparam logic [31:0] pattern_key = 32'h5a3c9e71;
  localparam int burst_loads = 30;
  localparam int cycles_per_row = 40;

  typedef enum logic [1:0] {op_load, op_store, op_burst, op_bus_store} op_e;

  typedef struct packed {
    op_e         op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  byte_en;
    logic [1:0]  flag;  // load 0 miss, 1 hit, 2 either; store stall after
  } row_t;

  logic                 clock;
  logic                 reset;
  load_request_t        load_in;
  store_request_t       store_in;
  logic                 load_hit;
  logic [31:0]          load_data;
  logic                 load_stall;
  logic                 store_stall;
  logic                 broadcast_valid;
  logic [31:0]          broadcast_data;
  mem_request_t         mem_request;
  logic [3:0]           mem_response;
  logic [3:0]           mem_tag;
  logic [63:0]          mem_data;

  row_t        rows [$];
  string       names [$];
  logic [7:0]  golden [logic [31:0]];  // bytes written so far
  logic [31:0] expected_q [$];
  string       expected_names [$];
  bit          load_seen [logic [31:0]];
  bit          store_seen [logic [31:0]];
  bit          saw_load_stall;

  dcache dut_i (.*);

  mem_controller_model #(.pattern_key(pattern_key)) mem_i (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [7:0] golden_byte(logic [31:0] a);
    logic [31:0] word;
    word = {a[31:2], 2'b00} ^ pattern_key;
    if (golden.exists(a)) begin
      return golden[a];
    end
    return word[8*a[1:0] +: 8];
  endfunction

  function automatic logic [31:0] golden_word(logic [31:0] a);
    return {golden_byte(a + 3), golden_byte(a + 2), golden_byte(a + 1), golden_byte(a)};
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    assert (expected === actual) else begin
      report_failure($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic add_row(op_e op, logic [31:0] addr, logic [31:0] data, logic [3:0] byte_en,
                         logic [1:0] flag, string name);
    rows.push_back('{op, addr, data, byte_en, flag});
    names.push_back(name);
  endtask

  task automatic build_table();
    add_row(op_load, 32'h0000_1010, '0, '0, 2'd0, "cold_load_miss");
    add_row(op_load, 32'h0000_1010, '0, '0, 2'd1, "reload_hit");
    add_row(op_load, 32'h0000_1014, '0, '0, 2'd1, "other_half_hit");
    add_row(op_store, 32'h0000_1010, 32'hdead_beef, 4'b0110, 2'd0, "store_hit_partial");
    add_row(op_load, 32'h0000_1010, '0, '0, 2'd1, "load_after_store_hit");
    add_row(op_store, 32'h0000_2024, 32'h1234_5678, 4'b1001, 2'd1, "store_miss");
    add_row(op_load, 32'h0000_2024, '0, '0, 2'd1, "load_after_store_miss");
    add_row(op_load, 32'h0000_2020, '0, '0, 2'd1, "store_miss_other_half");
    add_row(op_load, 32'h0000_1110, '0, '0, 2'd0, "same_index_evict");  // index 2 again
    add_row(op_bus_store, 32'h0000_1010, '0, '0, 2'd0, "evict_bus_store");
    add_row(op_load, 32'h0000_1010, '0, '0, 2'd0, "reload_evicted");
    for (int i = 0; i < burst_loads; i++) begin
      add_row(op_burst, 32'h0004_0000 + 32'(i * 8 + (i % 2) * 4), '0, '0, 2'd2,
              $sformatf("burst_%0d", i));
    end
  endtask

  task automatic step_idle();
    @(posedge clock);
    #10;
    load_in = '0;
    store_in = '0;
  endtask

  task automatic drain_loads();
    while (expected_q.size() != 0) begin
      @(posedge clock);
      #50;
    end
  endtask

  task automatic do_load(row_t row, string name);
    logic [31:0] block;
    logic        hit;
    block = {row.addr[31:3], 3'b000};
    step_idle();
    load_in.start = 1'b1;
    load_in.addr = row.addr;
    #40;
    while (load_stall) begin
      if (row.op == op_burst) begin
        saw_load_stall = 1'b1;
      end
      @(posedge clock);
      #50;
    end
    hit = load_hit;
    if (row.flag != 2'd2) begin
      check_value({name, " hit"}, 64'(row.flag), 64'(hit));
    end
    if (hit) begin
      check_value(name, 64'(golden_word(row.addr)), 64'(load_data));
    end else begin
      load_seen.delete(block);
      expected_q.push_back(golden_word(row.addr));
      expected_names.push_back(name);
    end
    if (row.op == op_load) begin
      step_idle();
      drain_loads();
      assert (hit || load_seen.exists(block)) else begin
        report_failure($sformatf("no bus load was issued for %s", name));
      end
    end
  endtask

  task automatic do_store(row_t row, string name);
    step_idle();
    store_in.valid = 1'b1;
    store_in.addr = row.addr;
    store_in.data = row.data;
    store_in.byte_en = row.byte_en;
    #40;
    while (store_stall) begin
      @(posedge clock);
      #50;
    end
    for (int j = 0; j < 4; j++) begin
      if (row.byte_en[j]) begin
        golden[row.addr + 32'(j)] = row.data[8*j +: 8];
      end
    end
    step_idle();
    #40;
    check_value({name, " stall"}, 64'(row.flag), 64'(store_stall));
  endtask

  task automatic wait_bus_store(row_t row);
    step_idle();
    while (!store_seen.exists(row.addr)) begin
      @(posedge clock);
      #50;
    end
  endtask

  // broadcasts may finish out of order
  task automatic match_broadcast();
    int found;
    found = -1;
    assert (expected_q.size() != 0) else begin
      report_failure("broadcast arrived with no load outstanding");
    end
    foreach (expected_q[i]) begin
      if (found < 0 && expected_q[i] == broadcast_data) begin
        found = i;
      end
    end
    if (found < 0) begin
      check_value(expected_names[0], 64'(expected_q[0]), 64'(broadcast_data));
    end
    expected_q.delete(found);
    expected_names.delete(found);
  endtask

  // bus and broadcast monitor, mid cycle
  initial begin
    forever begin
      @(posedge clock);
      #50;
      if (!reset && mem_request.command != bus_none && mem_response != '0) begin
        if (mem_request.command == bus_load) begin
          load_seen[mem_request.addr] = 1'b1;
        end else begin
          store_seen[mem_request.addr] = 1'b1;
          check_value($sformatf("bus store %h", mem_request.addr),
                      {golden_word(mem_request.addr + 4), golden_word(mem_request.addr)},
                      mem_request.data);
        end
      end
      if (!reset && broadcast_valid) begin
        match_broadcast();
      end
    end
  end

  initial begin
    #1;
    repeat (rows.size() * cycles_per_row) @(posedge clock);
    report_failure($sformatf("watchdog timeout after %0d cycles", rows.size() * cycles_per_row));
  end

  initial begin
    reset = 1'b1;
    load_in = '0;
    store_in = '0;
    saw_load_stall = 1'b0;
    build_table();
    repeat (2) @(posedge clock);
    #10;
    reset = 1'b0;
    foreach (rows[r]) begin
      case (rows[r].op)
        op_store: do_store(rows[r], names[r]);
        op_bus_store: wait_bus_store(rows[r]);
        default: do_load(rows[r], names[r]);
      endcase
    end
    step_idle();
    drain_loads();
    assert (saw_load_stall) else begin
      report_failure("load_stall never went high during the miss burst");
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

/* dcache.f */
design/mem_bus_pkg.sv
design/dcache_types_pkg.sv
design/dcache_request_stage.sv
design/dcache_array.sv
design/dcache_miss_queue.sv
design/dcache.sv
testbench/mem_controller_model.sv
testbench/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
  -f dcache.f -o dcache_sim &&
  ./obj_dir/dcache_sim | tee sim.log &&
  grep -q "^TB PASSED$" sim.log ||
  { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
